/* dtfag.f */
rtl/dtfag_pkg.sv
rtl/dtfag_agu.sv
rtl/dtfag_tf_rom.sv
rtl/dtfag_mod_mul.sv
rtl/dtfag_top.sv
sim/dtfag_sva.sv
sim/dtfag_tb.sv

/* rtl/dtfag_agu.sv */
`timescale 1ns/100ps
`default_nettype none

module dtfag_agu #(
    parameter int LANES = dtfag_pkg::LANES,
    parameter int TF_ORDER = dtfag_pkg::TF_ORDER
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             rom_cen,
    input  logic [dtfag_pkg::RADIX_WIDTH-1:0] tf_i,
    input  logic [dtfag_pkg::RADIX_WIDTH-1:0] tf_t,
    input  logic [dtfag_pkg::RADIX_WIDTH-1:0] tf_j,
    input  dtfag_pkg::mul_sel_e              mul_sel,
    input  dtfag_pkg::data_t                 data_in [LANES],
    output logic                             stage_valid,
    output dtfag_pkg::exp_t                  lane_exp [LANES],
    output dtfag_pkg::data_t                 lane_data [LANES],
    output dtfag_pkg::mul_sel_e              lane_sel
);

    // j * (16t + i) never exceeds three index widths
    localparam int IW = 3 * dtfag_pkg::RADIX_WIDTH;

    logic [IW-1:0] prod_ji;
    int unsigned base_exp;
    dtfag_pkg::exp_t lane_exp_d [LANES];

    always_comb begin
        prod_ji = IW'(tf_j) * IW'({tf_t, tf_i});
        base_exp = 32'(prod_ji) % TF_ORDER;
        // lane k uses the k-th power of the base twiddle
        for (int k = 0; k < LANES; k++) begin
            lane_exp_d[k] = dtfag_pkg::exp_t'((k * base_exp) % TF_ORDER);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_valid <= 1'b0;
            lane_sel <= dtfag_pkg::MUL_TWIDDLE;
            for (int k = 0; k < LANES; k++) begin
                lane_exp[k] <= '0;
                lane_data[k] <= '0;
            end
        end else begin
            // active-low enable becomes the valid flag
            stage_valid <= ~rom_cen;
            lane_sel <= mul_sel;
            for (int k = 0; k < LANES; k++) begin
                lane_exp[k] <= lane_exp_d[k];
                lane_data[k] <= data_in[k];
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/dtfag_mod_mul.sv */
`timescale 1ns/100ps
`default_nettype none

module dtfag_mod_mul #(
    parameter int LANES = dtfag_pkg::LANES
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                stage_valid_in,
    input  dtfag_pkg::data_t    twiddle [LANES],
    input  dtfag_pkg::data_t    lane_data_in [LANES],
    input  dtfag_pkg::mul_sel_e lane_sel_in,
    output logic                out_valid,
    output dtfag_pkg::data_t    data_out [LANES]
);

    // first cycle registers
    logic                valid_q;
    logic [31:0]         prod_q [LANES];
    dtfag_pkg::data_t    data_q [LANES];
    dtfag_pkg::data_t    tf_q [LANES];
    dtfag_pkg::mul_sel_e sel_q;

    // second cycle, combinational part
    logic [47:0]      quot_full [LANES];
    logic [31:0]      rem [LANES];
    dtfag_pkg::data_t prod_mod [LANES];
    dtfag_pkg::data_t result [LANES];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            sel_q <= dtfag_pkg::MUL_TWIDDLE;
            for (int k = 0; k < LANES; k++) begin
                prod_q[k] <= '0;
                data_q[k] <= '0;
                tf_q[k] <= '0;
            end
        end else begin
            valid_q <= stage_valid_in;
            sel_q <= lane_sel_in;
            for (int k = 0; k < LANES; k++) begin
                prod_q[k] <= 32'(lane_data_in[k]) * 32'(twiddle[k]);
                data_q[k] <= lane_data_in[k];
                tf_q[k] <= twiddle[k];
            end
        end
    end

    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            // quotient estimate is at most one short, so rem < 2Q
            quot_full[k] = 48'(prod_q[k]) * 48'(dtfag_pkg::BARRETT_M);
            rem[k] = prod_q[k]
                   - 32'(quot_full[k] >> dtfag_pkg::BARRETT_K) * 32'(dtfag_pkg::Q);
            if (rem[k] >= dtfag_pkg::Q) begin
                prod_mod[k] = dtfag_pkg::data_t'(rem[k] - dtfag_pkg::Q);
            end else begin
                prod_mod[k] = dtfag_pkg::data_t'(rem[k]);
            end

            case (sel_q)
                dtfag_pkg::MUL_TWIDDLE: result[k] = prod_mod[k];
                dtfag_pkg::MUL_BYPASS:  result[k] = data_q[k];
                dtfag_pkg::MUL_TF_ONLY: result[k] = tf_q[k];
                default:                result[k] = '0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            for (int k = 0; k < LANES; k++) begin
                data_out[k] <= '0;
            end
        end else begin
            out_valid <= valid_q;
            for (int k = 0; k < LANES; k++) begin
                data_out[k] <= result[k];
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/dtfag_pkg.sv */
`default_nettype none

package dtfag_pkg;

    localparam int LANES = 16;
    localparam int RADIX_WIDTH = 4;
    localparam int D_WIDTH = 16;
    localparam int EXP_WIDTH = 9;
    localparam int TF_ORDER = 512;

    // prime modulus, 3 * 2^12 + 1
    localparam int unsigned Q = 12289;

    // products stay below Q*Q < 2^28
    localparam int unsigned BARRETT_K = 28;
    localparam int unsigned BARRETT_M = (32'd1 << BARRETT_K) / Q;

    typedef logic [D_WIDTH-1:0] data_t;
    typedef logic [EXP_WIDTH-1:0] exp_t;

    // code 3 is reserved and gives zero
    typedef enum logic [1:0] {
        MUL_TWIDDLE = 2'd0,
        MUL_BYPASS  = 2'd1,
        MUL_TF_ONLY = 2'd2
    } mul_sel_e;

    function automatic int unsigned pow_mod(int unsigned base, int unsigned e);
        int unsigned acc;
        int unsigned b;
        acc = 1;
        b = base % Q;
        for (int unsigned n = 0; n < e; n++) begin
            acc = (acc * b) % Q;
        end
        return acc;
    endfunction

    // table root, 3^24 mod Q
    localparam int unsigned OMEGA = pow_mod(3, 24);

endpackage

`default_nettype wire

/* rtl/dtfag_tf_rom.sv */
`timescale 1ns/100ps
`default_nettype none

module dtfag_tf_rom #(
    parameter int LANES = dtfag_pkg::LANES,
    parameter int TF_ORDER = dtfag_pkg::TF_ORDER
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                stage_valid_in,
    input  dtfag_pkg::exp_t     lane_exp [LANES],
    input  dtfag_pkg::data_t    lane_data_in [LANES],
    input  dtfag_pkg::mul_sel_e lane_sel_in,
    output logic                stage_valid,
    output dtfag_pkg::data_t    twiddle [LANES],
    output dtfag_pkg::data_t    lane_data [LANES],
    output dtfag_pkg::mul_sel_e lane_sel
);

    dtfag_pkg::data_t tf_table [TF_ORDER];

    // successive powers of the root, entry n holds OMEGA^n mod Q
    initial begin
        int unsigned acc;
        acc = 1;
        for (int n = 0; n < TF_ORDER; n++) begin
            tf_table[n] = dtfag_pkg::data_t'(acc);
            acc = (acc * dtfag_pkg::OMEGA) % dtfag_pkg::Q;
        end
    end

    // 16 read ports, one per lane
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_valid <= 1'b0;
            lane_sel <= dtfag_pkg::MUL_TWIDDLE;
            for (int k = 0; k < LANES; k++) begin
                twiddle[k] <= '0;
                lane_data[k] <= '0;
            end
        end else begin
            stage_valid <= stage_valid_in;
            lane_sel <= lane_sel_in;
            for (int k = 0; k < LANES; k++) begin
                twiddle[k] <= tf_table[lane_exp[k]];
                lane_data[k] <= lane_data_in[k];
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/dtfag_top.sv */
`timescale 1ns/100ps
`default_nettype none

module dtfag_top #(
    parameter int LANES = dtfag_pkg::LANES,
    parameter int TF_ORDER = dtfag_pkg::TF_ORDER
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             rom_cen,
    input  logic [dtfag_pkg::RADIX_WIDTH-1:0] tf_i,
    input  logic [dtfag_pkg::RADIX_WIDTH-1:0] tf_t,
    input  logic [dtfag_pkg::RADIX_WIDTH-1:0] tf_j,
    input  dtfag_pkg::mul_sel_e              mul_sel,
    input  dtfag_pkg::data_t                 data_in [LANES],
    output dtfag_pkg::data_t                 data_out [LANES],
    output logic                             out_valid
);

    // agu to table
    logic                agu_valid;
    dtfag_pkg::exp_t     agu_exp [LANES];
    dtfag_pkg::data_t    agu_data [LANES];
    dtfag_pkg::mul_sel_e agu_sel;

    // table to multiplier
    logic                rom_valid;
    dtfag_pkg::data_t    rom_twiddle [LANES];
    dtfag_pkg::data_t    rom_data [LANES];
    dtfag_pkg::mul_sel_e rom_sel;

    dtfag_agu #(
        .LANES    (LANES),
        .TF_ORDER (TF_ORDER)
    ) u_agu (
        .clk         (clk),
        .rst_n       (rst_n),
        .rom_cen     (rom_cen),
        .tf_i        (tf_i),
        .tf_t        (tf_t),
        .tf_j        (tf_j),
        .mul_sel     (mul_sel),
        .data_in     (data_in),
        .stage_valid (agu_valid),
        .lane_exp    (agu_exp),
        .lane_data   (agu_data),
        .lane_sel    (agu_sel)
    );

    dtfag_tf_rom #(
        .LANES    (LANES),
        .TF_ORDER (TF_ORDER)
    ) u_tf_rom (
        .clk            (clk),
        .rst_n          (rst_n),
        .stage_valid_in (agu_valid),
        .lane_exp       (agu_exp),
        .lane_data_in   (agu_data),
        .lane_sel_in    (agu_sel),
        .stage_valid    (rom_valid),
        .twiddle        (rom_twiddle),
        .lane_data      (rom_data),
        .lane_sel       (rom_sel)
    );

    // two cycles, product then reduce and select
    dtfag_mod_mul #(
        .LANES (LANES)
    ) u_mod_mul (
        .clk            (clk),
        .rst_n          (rst_n),
        .stage_valid_in (rom_valid),
        .twiddle        (rom_twiddle),
        .lane_data_in   (rom_data),
        .lane_sel_in    (rom_sel),
        .out_valid      (out_valid),
        .data_out       (data_out)
    );

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# build and run the dtfag testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module dtfag_tb -f dtfag.f

if ! output=$(./obj_dir/Vdtfag_tb 2>&1); then
    echo "$output"
    echo "simulation exited with an error"
    exit 1
fi

echo "$output"

if grep -q "^STATUS: PASS$" <<< "$output"; then
    exit 0
else
    exit 1
fi

/* sim/dtfag_sva.sv */
`timescale 1ns/100ps
`default_nettype none

module dtfag_sva #(
    parameter int LANES = dtfag_pkg::LANES
) (
    input logic             clk,
    input logic             rst_n,
    input logic             rom_cen,
    input logic             out_valid,
    input dtfag_pkg::data_t data_out [LANES]
);

    a_reset_idle: assert property (@(posedge clk) !rst_n |-> !out_valid)
        else $error("out_valid high while reset is held");

    // four register stages from enable sample to output
    a_issue_valid: assert property (@(posedge clk) disable iff (!rst_n)
        !rom_cen |-> ##4 out_valid)
        else $error("enabled group did not reach the output after four cycles");

    a_idle_slot: assert property (@(posedge clk) disable iff (!rst_n)
        rom_cen |-> ##4 !out_valid)
        else $error("out_valid high for a slot issued with rom_cen high");

    for (genvar k = 0; k < LANES; k++) begin : g_lane
        a_below_q: assert property (@(posedge clk) disable iff (!rst_n)
            out_valid |-> 32'(data_out[k]) < dtfag_pkg::Q)
            else $error("lane %0d output not reduced below Q", k);
    end

endmodule

bind dtfag_top dtfag_sva #(
    .LANES (LANES)
) u_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .rom_cen   (rom_cen),
    .out_valid (out_valid),
    .data_out  (data_out)
);

`default_nettype wire

/* sim/dtfag_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module dtfag_tb;

    localparam int LANES = dtfag_pkg::LANES;
    localparam int NUM_ENTRIES = 48;
    localparam int NUM_TESTS = 5;
    // rising edges from enable sample to visible output, seen from the falling edge
    localparam int LATENCY = 4;
    localparam int MAX_CYCLES = NUM_ENTRIES + LATENCY + 2 + 20;

    // one stimulus row, lane data is derived from the seed
    typedef struct packed {
        logic [3:0]  i;
        logic [3:0]  t;
        logic [3:0]  j;
        logic [1:0]  sel;
        logic        cen;
        logic [31:0] seed;
        logic [2:0]  test;
    } entry_t;

    logic                              clk;
    logic                              rst_n;
    logic                              rom_cen;
    logic [dtfag_pkg::RADIX_WIDTH-1:0] tf_i;
    logic [dtfag_pkg::RADIX_WIDTH-1:0] tf_t;
    logic [dtfag_pkg::RADIX_WIDTH-1:0] tf_j;
    dtfag_pkg::mul_sel_e               mul_sel;
    dtfag_pkg::data_t                  data_in [LANES];
    dtfag_pkg::data_t                  data_out [LANES];
    logic                              out_valid;

    entry_t           stim [NUM_ENTRIES];
    dtfag_pkg::data_t stim_data [NUM_ENTRIES][LANES];
    dtfag_pkg::data_t exp_data [NUM_ENTRIES][LANES];
    logic             exp_valid [NUM_ENTRIES];
    int               due_cycle [NUM_ENTRIES];
    int               pending [$];

    logic [31:0] rng_state;
    int unsigned omega;
    int          neg_cycle;
    int          cycle_cnt = 0;
    int          test_checks [NUM_TESTS];
    int          test_errs [NUM_TESTS];
    int          idle_checks;
    int          idle_errs;
    int          total_checks;
    int          total_errs;
    int          tests_done;
    bit          first_out_seen;

    dtfag_top #(
        .LANES    (LANES),
        .TF_ORDER (dtfag_pkg::TF_ORDER)
    ) dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .rom_cen   (rom_cen),
        .tf_i      (tf_i),
        .tf_t      (tf_t),
        .tf_j      (tf_j),
        .mul_sel   (mul_sel),
        .data_in   (data_in),
        .data_out  (data_out),
        .out_valid (out_valid)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d clock cycles", MAX_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // plain repeated multiply, slow but obviously right
    function automatic int unsigned mod_pow(int unsigned base, int unsigned e);
        int unsigned acc;
        acc = 1;
        for (int unsigned n = 0; n < e; n++) begin
            acc = (acc * base) % dtfag_pkg::Q;
        end
        return acc;
    endfunction

    function automatic dtfag_pkg::data_t lane_word(logic [31:0] seed, int k);
        logic [31:0] s;
        s = seed;
        for (int n = 0; n <= k; n++) begin
            s = xorshift(s);
        end
        return dtfag_pkg::data_t'(s % dtfag_pkg::Q);
    endfunction

    function automatic string test_name(int id);
        case (id)
            0: return "tf_only_j0";
            1: return "omega_powers";
            2: return "twiddle_random";
            3: return "bypass";
            default: return "cen_gaps";
        endcase
    endfunction

    task automatic set_entry(int idx, int test, int i, int t, int j,
                             dtfag_pkg::mul_sel_e sel, int cen);
        stim[idx].i = 4'(i);
        stim[idx].t = 4'(t);
        stim[idx].j = 4'(j);
        stim[idx].sel = sel;
        stim[idx].cen = 1'(cen);
        stim[idx].seed = next_rand() | 32'd1;
        stim[idx].test = 3'(test);
        for (int k = 0; k < LANES; k++) begin
            stim_data[idx][k] = lane_word(stim[idx].seed, k);
        end
    endtask

    // reference: e = j*(16t+i), lane exponent k*e, both mod table depth
    task automatic compute_expected(int idx);
        int unsigned e;
        int unsigned ex;
        int unsigned tw;
        int unsigned d;
        int unsigned prod;
        e = (32'(stim[idx].j) * (32'd16 * 32'(stim[idx].t) + 32'(stim[idx].i)))
            % dtfag_pkg::TF_ORDER;
        exp_valid[idx] = ~stim[idx].cen;
        for (int k = 0; k < LANES; k++) begin
            ex = (k * e) % dtfag_pkg::TF_ORDER;
            tw = mod_pow(omega, ex);
            d = 32'(stim_data[idx][k]);
            prod = (d * tw) % dtfag_pkg::Q;
            case (dtfag_pkg::mul_sel_e'(stim[idx].sel))
                dtfag_pkg::MUL_TWIDDLE: exp_data[idx][k] = dtfag_pkg::data_t'(prod);
                dtfag_pkg::MUL_BYPASS:  exp_data[idx][k] = dtfag_pkg::data_t'(d);
                dtfag_pkg::MUL_TF_ONLY: exp_data[idx][k] = dtfag_pkg::data_t'(tw);
                default:                exp_data[idx][k] = '0;
            endcase
        end
    endtask

    task automatic fill_table();
        int idx;
        logic [31:0] r;
        idx = 0;
        // j = 0, every lane reads exponent 0
        for (int n = 0; n < 4; n++) begin
            r = next_rand();
            set_entry(idx, 0, int'(r[3:0]), int'(r[7:4]), 0, dtfag_pkg::MUL_TF_ONLY, 0);
            idx++;
        end
        set_entry(idx, 1, 1, 0, 1, dtfag_pkg::MUL_TF_ONLY, 0);
        idx++;
        set_entry(idx, 1, 1, 0, 1, dtfag_pkg::MUL_TF_ONLY, 0);
        idx++;
        // largest indices, lane exponents wrap many times
        set_entry(idx, 2, 15, 15, 15, dtfag_pkg::MUL_TWIDDLE, 0);
        idx++;
        for (int n = 0; n < 23; n++) begin
            r = next_rand();
            set_entry(idx, 2, int'(r[3:0]), int'(r[7:4]), int'(r[11:8]),
                      dtfag_pkg::MUL_TWIDDLE, 0);
            idx++;
        end
        for (int n = 0; n < 6; n++) begin
            r = next_rand();
            set_entry(idx, 3, int'(r[3:0]), int'(r[7:4]), int'(r[11:8]),
                      dtfag_pkg::MUL_BYPASS, 0);
            idx++;
        end
        // every third slot idle, mixed select codes
        for (int n = 0; n < 12; n++) begin
            r = next_rand();
            set_entry(idx, 4, int'(r[3:0]), int'(r[7:4]), int'(r[11:8]),
                      dtfag_pkg::mul_sel_e'(int'(r[17:16]) % 3), (n % 3 == 1) ? 1 : 0);
            idx++;
        end
        for (int n = 0; n < NUM_ENTRIES; n++) begin
            compute_expected(n);
        end
    endtask

    task automatic report_test(string name, int checks, int errs);
        $display("test %-14s %5d checks %4d errors", name, checks, errs);
        tests_done++;
    endtask

    task automatic check_outputs();
        int idx;
        int tid;
        if (pending.size() != 0 && due_cycle[pending[0]] == neg_cycle) begin
            idx = pending.pop_front();
            tid = int'(stim[idx].test);
            if (!first_out_seen) begin
                first_out_seen = 1'b1;
                report_test("reset_idle", idle_checks, idle_errs);
            end
            test_checks[tid]++;
            total_checks++;
            if (out_valid !== exp_valid[idx]) begin
                $display("ERR @%0t: entry %0d out_valid expected %0b actual %0b",
                         $time, idx, exp_valid[idx], out_valid);
                test_errs[tid]++;
                total_errs++;
            end else if (exp_valid[idx]) begin
                for (int k = 0; k < LANES; k++) begin
                    test_checks[tid]++;
                    total_checks++;
                    if (data_out[k] !== exp_data[idx][k]) begin
                        $display("ERR @%0t: entry %0d lane %0d expected %0d actual %0d",
                                 $time, idx, k, exp_data[idx][k], data_out[k]);
                        test_errs[tid]++;
                        total_errs++;
                    end
                end
            end
            if (idx == NUM_ENTRIES - 1 || stim[idx + 1].test != stim[idx].test) begin
                report_test(test_name(tid), test_checks[tid], test_errs[tid]);
            end
        end else begin
            idle_checks++;
            total_checks++;
            if (out_valid !== 1'b0) begin
                $display("ERR @%0t: out_valid expected 0 actual %0b with no group due",
                         $time, out_valid);
                idle_errs++;
                total_errs++;
            end
        end
    endtask

    task automatic drive_entry(int idx);
        rom_cen = stim[idx].cen;
        tf_i = stim[idx].i;
        tf_t = stim[idx].t;
        tf_j = stim[idx].j;
        mul_sel = dtfag_pkg::mul_sel_e'(stim[idx].sel);
        for (int k = 0; k < LANES; k++) begin
            data_in[k] = stim_data[idx][k];
        end
        due_cycle[idx] = neg_cycle + LATENCY;
        pending.push_back(idx);
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b1;
        rom_cen = 1'b1;
        tf_i = '0;
        tf_t = '0;
        tf_j = '0;
        mul_sel = dtfag_pkg::MUL_TWIDDLE;
        for (int k = 0; k < LANES; k++) begin
            data_in[k] = '0;
        end
        rng_state = 32'h956e7e02;
        omega = mod_pow(3, 24);
        neg_cycle = 0;
        idle_checks = 0;
        idle_errs = 0;
        total_checks = 0;
        total_errs = 0;
        tests_done = 0;
        first_out_seen = 1'b0;
        for (int n = 0; n < NUM_TESTS; n++) begin
            test_checks[n] = 0;
            test_errs[n] = 0;
        end
        fill_table();

        #1 rst_n = 1'b0;
        repeat (2) begin
            @(negedge clk);
            neg_cycle++;
            check_outputs();
        end
        rst_n = 1'b1;

        // back to back, one row per clock
        for (int n = 0; n < NUM_ENTRIES; n++) begin
            @(negedge clk);
            neg_cycle++;
            check_outputs();
            drive_entry(n);
        end
        repeat (LATENCY + 4) begin
            @(negedge clk);
            neg_cycle++;
            check_outputs();
            rom_cen = 1'b1;
        end

        if (pending.size() != 0) begin
            $display("%0d issued groups never reached the output", pending.size());
            total_errs++;
        end
        $display("summary: %0d tests, %0d checks, %0d errors",
                 tests_done, total_checks, total_errs);
        if (total_errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
